//--- project.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_timer.sv
hdl/csr_file.sv
hdl/csr_issue.sv
hdl/csr_control.sv
bench/csr_assertions.sv
bench/csr_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the csr unit testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f project.f --top-module csr_tb -Mdir obj_dir -o csr_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/csr_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- bench/csr_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_tb import csr_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int WAIT_LIMIT = 64;
    localparam int POLL_LIMIT = 100;

    logic               clk;
    logic               rstn;
    logic               stall;
    logic               inst_valid;
    csr_op_t            inst_op;
    csr_num_t           csr_num;
    logic [`XLEN-1:0]   wdata;
    logic [`XLEN-1:0]   wmask;
    logic [`XLEN-1:0]   pc;
    ecode_t             excp_ecode;
    logic [`HWI_N-1:0]  hw_int;
    logic [`XLEN-1:0]   rdata;
    logic               flush;
    logic [`XLEN-1:0]   flush_pc;
    logic [1:0]         plv;
    logic               ie;

    integer seed = 32'hbfaf_6edf;

    // reference model of the kept registers
    logic [8:0]   m_crmd;
    logic [2:0]   m_prmd;
    logic [12:0]  m_ecfg;
    logic [1:0]   m_is;
    ecode_t       m_ecode;
    logic [31:0]  m_era;
    logic [31:0]  m_eentry;
    logic [31:0]  m_tid;
    logic [31:0]  m_tcfg;
    logic [31:0]  m_save [4];
    logic         m_ti;
    logic [31:0]  rd_ignore;     // rdata bits not compared

    csr_control u_dut (
        .clk(clk), .rstn(rstn), .stall(stall),
        .inst_valid(inst_valid), .inst_op(inst_op), .csr_num(csr_num),
        .wdata(wdata), .wmask(wmask), .pc(pc), .excp_ecode(excp_ecode), .hw_int(hw_int),
        .rdata(rdata), .flush(flush), .flush_pc(flush_pc), .plv(plv), .ie(ie)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERROR: %s is %h, expected %h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    endtask

    function automatic logic rand_stall();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0] == 2'b00;   // about one edge in four
    endfunction

    function automatic logic [31:0] model_read(input csr_num_t num);
        logic [31:0] v;
        v = '0;
        case (num)
            `CSR_CRMD:   v[8:0] = m_crmd;
            `CSR_PRMD:   v[2:0] = m_prmd;
            `CSR_ECFG:   v[12:0] = m_ecfg;
            `CSR_ESTAT:  v = {10'd0, m_ecode, 4'd0, m_ti, 1'b0, hw_int, m_is};
            `CSR_ERA:    v = m_era;
            `CSR_EENTRY: v = m_eentry;
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3: v = m_save[num[1:0]];
            `CSR_TID:    v = m_tid;
            `CSR_TCFG:   v = m_tcfg;
            default:     v = '0;
        endcase
        return v;
    endfunction

    function automatic void model_write(input csr_num_t num, input logic [31:0] d);
        case (num)
            `CSR_CRMD:   m_crmd = d[8:0];
            `CSR_PRMD:   m_prmd = d[2:0];
            `CSR_ECFG:   m_ecfg = d[12:0] & 13'h1bff;   // bit 10 is reserved
            `CSR_ESTAT:  m_is = d[1:0];
            `CSR_ERA:    m_era = d;
            `CSR_EENTRY: m_eentry = {d[31:6], 6'd0};
            `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3: m_save[num[1:0]] = d;
            `CSR_TID:    m_tid = d;
            `CSR_TCFG:   m_tcfg = d;
            `CSR_TICLR:
            begin
                if (d[0])
                    m_ti = 1'b0;
            end
            default:     ;
        endcase
    endfunction

    function automatic logic model_int_pending();
        return m_crmd[2] && |({m_ti, 1'b0, hw_int, m_is} & m_ecfg[11:0]);
    endfunction

    function automatic csr_num_t rw_num(input int k);
        case (k)
            0: return `CSR_SAVE0;
            1: return `CSR_SAVE1;
            2: return `CSR_SAVE2;
            3: return `CSR_SAVE3;
            4: return `CSR_TID;
            5: return `CSR_ERA;
            6: return `CSR_EENTRY;
            7: return `CSR_PRMD;
            default: return `CSR_ECFG;
        endcase
    endfunction

    // called at a falling edge, returns after a rising edge with stall low
    task automatic pass_edge(input string what);
        int n;
        n = 0;
        stall = rand_stall();
        @(posedge clk);
        while (stall)
        begin
            n++;
            if (n > WAIT_LIMIT)
                stop_on_timeout(what);
            @(negedge clk);
            stall = rand_stall();
            @(posedge clk);
        end
    endtask

    task automatic check_outputs(input logic [31:0] exp_rd, input logic exp_flush,
                                 input logic [31:0] exp_pc);
        check_eq("rdata", rdata & ~rd_ignore, exp_rd & ~rd_ignore);
        check_eq("flush", 32'(flush), 32'(exp_flush));
        check_eq("flush_pc", flush_pc, exp_pc);
    endtask

    // one instruction through accept and commit, then the model follows
    task automatic exec(input csr_op_t op, input csr_num_t num,
                        input logic [31:0] data, input logic [31:0] mask);
        logic [31:0] r;
        logic [31:0] old;
        logic [31:0] merged;
        logic [31:0] exp_rd;
        logic [31:0] exp_pc;
        csr_op_t     eff;
        ecode_t      code;
        r = $random(seed);
        code = (r[13:8] == 6'd0) ? 6'd1 : r[13:8];
        repeat (r[1:0])
        begin
            @(negedge clk);
            stall = rand_stall();
        end
        @(negedge clk);
        r = $random(seed);
        inst_valid = 1'b1;
        inst_op = op;
        csr_num = num;
        wdata = data;
        wmask = mask;
        pc = {r[31:2], 2'b00};
        excp_ecode = code;
        eff = model_int_pending() ? OP_INT : op;   // interrupt replaces anything
        old = model_read(num);
        merged = (op == OP_CSRXCHG) ? ((old & ~mask) | (data & mask)) : data;
        exp_rd = (eff == OP_CSRRD || eff == OP_CSRWR || eff == OP_CSRXCHG) ? old : '0;
        case (eff)
            OP_EXCP, OP_INT: exp_pc = m_eentry;
            OP_ERTN:         exp_pc = m_era;
            default:         exp_pc = pc + 32'd4;
        endcase
        pass_edge("instruction was never accepted");
        @(negedge clk);
        inst_valid = 1'b0;
        check_outputs(exp_rd, eff != OP_CSRRD, exp_pc);
        pass_edge("instruction never committed");
        case (eff)
            OP_CSRWR, OP_CSRXCHG: model_write(num, merged);
            OP_EXCP, OP_INT:
            begin
                m_prmd = m_crmd[2:0];
                m_crmd[2:0] = 3'b000;
                m_era = pc;
                m_ecode = (eff == OP_INT) ? `ECODE_INT : code;
            end
            OP_ERTN: m_crmd[2:0] = m_prmd;
            default: ;
        endcase
        @(negedge clk);
        check_outputs(exp_rd, eff != OP_CSRRD, exp_pc);   // held until next accept
        check_eq("plv", 32'(plv), 32'(m_crmd[1:0]));
        check_eq("ie", 32'(ie), 32'(m_crmd[2]));
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] d;
        int          k;
        int          n;
        rstn = 1'b0;
        stall = 1'b0;
        inst_valid = 1'b0;
        inst_op = OP_NONE;
        csr_num = '0;
        wdata = '0;
        wmask = '0;
        pc = '0;
        excp_ecode = '0;
        hw_int = '0;
        m_crmd = 9'(`CRMD_RESET);
        m_prmd = '0;
        m_ecfg = '0;
        m_is = '0;
        m_ecode = '0;
        m_era = '0;
        m_eentry = '0;
        m_tid = '0;
        m_tcfg = '0;
        m_ti = 1'b0;
        rd_ignore = '0;
        for (int i = 0; i < 4; i++)
            m_save[i] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        check_outputs('0, 1'b0, '0);
        check_eq("plv", 32'(plv), 32'd0);
        check_eq("ie", 32'(ie), 32'd0);
        exec(OP_CSRRD, `CSR_CRMD, '0, '0);
        check_eq("rdata", rdata, `CRMD_RESET);
        exec(OP_CSRRD, 14'h003, '0, '0);
        exec(OP_CSRRD, 14'h2abc, '0, '0);   // unknown numbers read zero

        for (int i = 0; i < 60; i++)
        begin
            r = $random(seed);
            d = $random(seed);
            exec(r[4] ? OP_CSRWR : OP_CSRRD, rw_num(r % 9), d, '0);
        end

        for (int i = 0; i < 30; i++)
        begin
            r = $random(seed);
            d = $random(seed);
            exec(OP_CSRXCHG, rw_num(r % 9), d, $random(seed));
        end

        // exception entry and return from a few modes
        for (int i = 0; i < 4; i++)
        begin
            r = $random(seed);
            exec(OP_CSRWR, `CSR_CRMD, {29'd1, r[2:0]}, '1);
            exec(OP_EXCP, `CSR_CRMD, '0, '0);
            exec(OP_CSRRD, `CSR_ERA, '0, '0);
            exec(OP_CSRRD, `CSR_PRMD, '0, '0);
            check_eq("rdata", rdata, {29'd0, r[2:0]});
            exec(OP_CSRRD, `CSR_ESTAT, '0, '0);
            exec(OP_ERTN, `CSR_CRMD, '0, '0);
            check_eq("plv", 32'(plv), 32'(r[1:0]));
            check_eq("ie", 32'(ie), 32'(r[2]));
        end

        // hardware interrupt on one random line
        r = $random(seed);
        k = int'(r[2:0]);
        exec(OP_CSRWR, `CSR_CRMD, 32'h0000_0008, '1);
        exec(OP_CSRWR, `CSR_EENTRY, $random(seed), '1);
        exec(OP_CSRWR, `CSR_ECFG, 32'd1 << (k + 2), '1);
        @(negedge clk);
        hw_int[k] = 1'b1;
        exec(OP_CSRWR, `CSR_CRMD, 32'h0000_000c, '1);   // ie on
        exec(OP_CSRRD, `CSR_SAVE0, '0, '0);
        check_eq("flush", 32'(flush), 32'd1);
        check_eq("flush_pc", flush_pc, m_eentry);
        check_eq("ie", 32'(ie), 32'd0);
        exec(OP_CSRRD, `CSR_ESTAT, '0, '0);
        check_eq("ecode", 32'(rdata[21:16]), 32'(`ECODE_INT));
        @(negedge clk);
        hw_int = '0;
        exec(OP_ERTN, `CSR_CRMD, '0, '0);
        exec(OP_CSRWR, `CSR_CRMD, 32'h0000_0008, '1);
        exec(OP_CSRWR, `CSR_ECFG, '0, '1);

        // one-shot timer of 0x40 ticks
        exec(OP_CSRWR, `CSR_TCFG, 32'h0000_0041, '1);
        exec(OP_CSRRD, `CSR_TCFG, '0, '0);
        rd_ignore = 32'd1 << `LIE_TI_BIT;
        n = 0;
        exec(OP_CSRRD, `CSR_ESTAT, '0, '0);
        while (!rdata[`LIE_TI_BIT])
        begin
            n++;
            if (n > POLL_LIMIT)
                stop_on_timeout("timer interrupt flag never came up in ESTAT");
            exec(OP_CSRRD, `CSR_ESTAT, '0, '0);
        end
        rd_ignore = '0;
        m_ti = 1'b1;
        exec(OP_CSRRD, `CSR_ESTAT, '0, '0);
        exec(OP_CSRWR, `CSR_TICLR, 32'd1, '1);
        exec(OP_CSRRD, `CSR_ESTAT, '0, '0);
        check_eq("estat_ti", 32'(rdata[`LIE_TI_BIT]), 32'd0);

        for (int i = 0; i < 9; i++)
            exec(OP_CSRRD, rw_num(i), '0, '0);

        if (u_dut.u_assert.fail_count == 0)
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
        begin
            $display("%0d assertion failures", u_dut.u_assert.fail_count);
            $display("=== FAIL ===");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

//--- bench/csr_assertions.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_assertions import csr_pkg::*;
(
    input  wire              clk,
    input  wire              rstn,
    input  wire              stall,
    input  wire              commit_valid,
    input  wire csr_op_t     commit_op,
    input  wire [`XLEN-1:0]  rdata,
    input  wire              flush,
    input  wire [`XLEN-1:0]  flush_pc,
    input  wire [1:0]        plv,
    input  wire              ie
);

    int unsigned fail_count = 0;   // read by the testbench verdict

    // registered outputs freeze under stall
    hold_under_stall: assert property (@(posedge clk) disable iff (!rstn)
        stall |=> $stable(flush) && $stable(flush_pc))
    else
    begin
        $error("flush or flush_pc moved while stall was high");
        fail_count = fail_count + 1;
    end

    int_entry_mode: assert property (@(posedge clk) disable iff (!rstn)
        (commit_valid && !stall && commit_op == OP_INT) |=> (!ie && plv == 2'd0))
    else
    begin
        $error("interrupt entry left ie or plv set");
        fail_count = fail_count + 1;
    end

    outputs_known: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown({rdata, flush, flush_pc, plv, ie}))
    else
    begin
        $error("unknown value on a csr_control output");
        fail_count = fail_count + 1;
    end

endmodule

bind csr_control csr_assertions u_assert (
    .clk(clk), .rstn(rstn), .stall(stall),
    .commit_valid(commit_valid), .commit_op(commit_op),
    .rdata(rdata), .flush(flush), .flush_pc(flush_pc), .plv(plv), .ie(ie)
);

`default_nettype wire

//--- hdl/csr_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_control import csr_pkg::*;
(
    input  wire               clk,
    input  wire               rstn,
    input  wire               stall,
    input  wire               inst_valid,
    input  wire csr_op_t      inst_op,
    input  wire csr_num_t     csr_num,
    input  wire [`XLEN-1:0]   wdata,
    input  wire [`XLEN-1:0]   wmask,
    input  wire [`XLEN-1:0]   pc,
    input  wire ecode_t       excp_ecode,
    input  wire [`HWI_N-1:0]  hw_int,
    output logic [`XLEN-1:0]  rdata,
    output logic              flush,
    output logic [`XLEN-1:0]  flush_pc,
    output logic [1:0]        plv,
    output logic              ie
);

    logic                commit_valid;
    csr_op_t             commit_op;
    csr_num_t            commit_num;
    logic [`XLEN-1:0]    commit_data;
    logic [`XLEN-1:0]    commit_pc;
    ecode_t              commit_ecode;
    logic [`XLEN-1:0]    cur_value;
    logic [`XLEN-1:0]    era;
    logic [`XLEN-1:0]    eentry;
    logic                int_pending;
    logic [`TIMER_N-1:0] tcfg_value;
    logic                tcfg_write;
    logic                ti_clear;
    logic [`TIMER_N-1:0] tval;
    logic                ti_flag;

    csr_issue u_issue (
        .clk(clk), .rstn(rstn), .stall(stall),
        .inst_valid(inst_valid), .inst_op(inst_op), .csr_num(csr_num),
        .wdata(wdata), .wmask(wmask), .pc(pc), .excp_ecode(excp_ecode),
        .cur_value(cur_value), .era(era), .eentry(eentry), .int_pending(int_pending),
        .rdata(rdata), .flush(flush), .flush_pc(flush_pc),
        .commit_valid(commit_valid), .commit_op(commit_op), .commit_num(commit_num),
        .commit_data(commit_data), .commit_pc(commit_pc), .commit_ecode(commit_ecode)
    );

    // read port follows the incoming csr number
    csr_file u_file (
        .clk(clk), .rstn(rstn),
        .commit_valid(commit_valid), .commit_op(commit_op), .commit_num(commit_num),
        .commit_data(commit_data), .commit_pc(commit_pc), .commit_ecode(commit_ecode),
        .stall(stall), .read_num(csr_num), .cur_value(cur_value), .hw_int(hw_int),
        .ti_flag(ti_flag), .tval(tval),
        .tcfg_value(tcfg_value), .tcfg_write(tcfg_write), .ti_clear(ti_clear),
        .era(era), .eentry(eentry), .int_pending(int_pending), .plv(plv), .ie(ie)
    );

    csr_timer u_timer (
        .clk(clk), .rstn(rstn),
        .tcfg_value(tcfg_value), .tcfg_write(tcfg_write), .ti_clear(ti_clear),
        .tval(tval), .ti_flag(ti_flag)
    );

endmodule

`default_nettype wire

//--- hdl/csr_issue.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_issue import csr_pkg::*;
(
    input  wire               clk,
    input  wire               rstn,
    input  wire               stall,
    input  wire               inst_valid,
    input  wire csr_op_t      inst_op,
    input  wire csr_num_t     csr_num,
    input  wire [`XLEN-1:0]   wdata,
    input  wire [`XLEN-1:0]   wmask,
    input  wire [`XLEN-1:0]   pc,
    input  wire ecode_t       excp_ecode,
    input  wire [`XLEN-1:0]   cur_value,
    input  wire [`XLEN-1:0]   era,
    input  wire [`XLEN-1:0]   eentry,
    input  wire               int_pending,
    output logic [`XLEN-1:0]  rdata,
    output logic              flush,
    output logic [`XLEN-1:0]  flush_pc,
    output logic              commit_valid,
    output csr_op_t           commit_op,
    output csr_num_t          commit_num,
    output logic [`XLEN-1:0]  commit_data,
    output logic [`XLEN-1:0]  commit_pc,
    output ecode_t            commit_ecode
);

    logic             accept;
    logic             take_int;
    csr_op_t          op;
    ecode_t           ecode;
    logic             is_csr;
    logic [`XLEN-1:0] mask;
    logic [`XLEN-1:0] merged;
    logic [`XLEN-1:0] next_pc;

    assign accept = inst_valid && !stall;

    // no second interrupt while an entry is still committing
    assign take_int = int_pending &&
                      !(commit_valid && (commit_op == OP_EXCP || commit_op == OP_INT));

    always_comb
    begin
        op    = inst_op;
        ecode = excp_ecode;
        if (take_int)
        begin
            op    = OP_INT;     // interrupt beats a reported exception
            ecode = `ECODE_INT;
        end
    end

    assign is_csr = op == OP_CSRRD || op == OP_CSRWR || op == OP_CSRXCHG;
    assign mask   = (op == OP_CSRXCHG) ? wmask : '1;
    assign merged = (cur_value & ~mask) | (wdata & mask);

    always_comb
    begin
        case (op)
            OP_EXCP, OP_INT: next_pc = eentry;
            OP_ERTN:         next_pc = era;
            default:         next_pc = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            commit_valid <= 1'b0;
            commit_op    <= OP_NONE;
            rdata        <= '0;
            flush        <= 1'b0;
            flush_pc     <= '0;
        end
        else if (!stall)
        begin
            commit_valid <= accept;   // stays up through a stall
            if (accept)
            begin
                commit_op <= op;
                rdata     <= is_csr ? cur_value : '0;
                flush     <= op != OP_CSRRD;
                flush_pc  <= next_pc;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            commit_num   <= csr_num;
            commit_data  <= merged;
            commit_pc    <= pc;
            commit_ecode <= ecode;
        end
    end

endmodule

`default_nettype wire

//--- hdl/csr_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_file import csr_pkg::*;
(
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 commit_valid,
    input  wire csr_op_t        commit_op,
    input  wire csr_num_t       commit_num,
    input  wire [`XLEN-1:0]     commit_data,
    input  wire [`XLEN-1:0]     commit_pc,
    input  wire ecode_t         commit_ecode,
    input  wire                 stall,
    input  wire csr_num_t       read_num,
    output logic [`XLEN-1:0]    cur_value,
    input  wire [`HWI_N-1:0]    hw_int,
    input  wire                 ti_flag,
    input  wire [`TIMER_N-1:0]  tval,
    output logic [`TIMER_N-1:0] tcfg_value,
    output logic                tcfg_write,
    output logic                ti_clear,
    output logic [`XLEN-1:0]    era,
    output logic [`XLEN-1:0]    eentry,
    output logic                int_pending,
    output logic [1:0]          plv,
    output logic                ie
);

    logic [8:0]         crmd;
    logic [2:0]         prmd;
    logic [12:0]        ecfg_lie;
    logic [1:0]         estat_is;    // software interrupt bits
    ecode_t             estat_ecode;
    logic [`XLEN-1:6]   eentry_base;
    logic [`XLEN-1:0]   save0, save1, save2, save3;
    logic [`XLEN-1:0]   tid;
    logic [`TIMER_N-1:0] tcfg;
    logic [`XLEN-1:0]   estat_value;
    logic               commit_en;
    logic               csr_write;

    assign commit_en = commit_valid && !stall;
    assign csr_write = commit_en && (commit_op == OP_CSRWR || commit_op == OP_CSRXCHG);
    assign ti_clear  = csr_write && commit_num == `CSR_TICLR && commit_data[0];

    assign plv        = crmd[1:0];
    assign ie         = crmd[2];
    assign eentry     = {eentry_base, 6'b0};
    assign tcfg_value = tcfg;

    always_comb
    begin
        estat_value                  = '0;
        estat_value[1:0]             = estat_is;
        estat_value[`HWI_N+1:2]      = hw_int;
        estat_value[`LIE_TI_BIT]     = ti_flag;
        estat_value[21:16]           = estat_ecode;
    end

    assign int_pending = ie && |(estat_value[12:0] & ecfg_lie);

    always_comb
    begin
        cur_value = '0;
        case (read_num)
            `CSR_CRMD:   cur_value[8:0] = crmd;
            `CSR_PRMD:   cur_value[2:0] = prmd;
            `CSR_ECFG:   cur_value[12:0] = ecfg_lie;
            `CSR_ESTAT:  cur_value = estat_value;
            `CSR_ERA:    cur_value = era;
            `CSR_EENTRY: cur_value = eentry;
            `CSR_SAVE0:  cur_value = save0;
            `CSR_SAVE1:  cur_value = save1;
            `CSR_SAVE2:  cur_value = save2;
            `CSR_SAVE3:  cur_value = save3;
            `CSR_TID:    cur_value = tid;
            `CSR_TCFG:   cur_value[`TIMER_N-1:0] = tcfg;
            `CSR_TVAL:   cur_value[`TIMER_N-1:0] = tval;
            default:     cur_value = '0;   // ticlr reads as zero too
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd        <= 9'(`CRMD_RESET);
            prmd        <= '0;
            ecfg_lie    <= '0;
            estat_is    <= '0;
            estat_ecode <= '0;
            era         <= '0;
            eentry_base <= '0;
            save0       <= '0;
            save1       <= '0;
            save2       <= '0;
            save3       <= '0;
            tid         <= '0;
            tcfg        <= '0;
            tcfg_write  <= 1'b0;
        end
        else
        begin
            tcfg_write <= 1'b0;
            if (csr_write)
            begin
                case (commit_num)
                    `CSR_CRMD:   crmd <= commit_data[8:0];
                    `CSR_PRMD:   prmd <= commit_data[2:0];
                    `CSR_ECFG:   ecfg_lie <= {commit_data[12:11], 1'b0, commit_data[9:0]};
                    `CSR_ESTAT:  estat_is <= commit_data[1:0];
                    `CSR_ERA:    era <= commit_data;
                    `CSR_EENTRY: eentry_base <= commit_data[`XLEN-1:6];
                    `CSR_SAVE0:  save0 <= commit_data;
                    `CSR_SAVE1:  save1 <= commit_data;
                    `CSR_SAVE2:  save2 <= commit_data;
                    `CSR_SAVE3:  save3 <= commit_data;
                    `CSR_TID:    tid <= commit_data;
                    `CSR_TCFG:
                    begin
                        tcfg       <= commit_data[`TIMER_N-1:0];
                        tcfg_write <= 1'b1;   // timer reloads next edge
                    end
                    default:     tcfg_write <= 1'b0;
                endcase
            end
            else if (commit_en && (commit_op == OP_EXCP || commit_op == OP_INT))
            begin
                prmd        <= crmd[2:0];    // save plv and ie
                crmd[2:0]   <= 3'b000;
                era         <= commit_pc;
                estat_ecode <= commit_ecode;
            end
            else if (commit_en && commit_op == OP_ERTN)
            begin
                crmd[2:0] <= prmd;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/csr_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_config.svh"

module csr_timer
(
    input  wire                 clk,
    input  wire                 rstn,
    input  wire [`TIMER_N-1:0]  tcfg_value,
    input  wire                 tcfg_write,
    input  wire                 ti_clear,
    output logic [`TIMER_N-1:0] tval,
    output logic                ti_flag
);

    logic                en;
    logic                periodic;
    logic [`TIMER_N-1:0] init_val;

    assign en       = tcfg_value[0];
    assign periodic = tcfg_value[1];
    assign init_val = {tcfg_value[`TIMER_N-1:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval    <= '0;
            ti_flag <= 1'b0;
        end
        else
        begin
            if (ti_clear)
                ti_flag <= 1'b0;
            else if (en && !tcfg_write && tval == '0)
                ti_flag <= 1'b1;

            if (en && tcfg_write)
                tval <= init_val;        // fresh config
            else if (!en)
                tval <= '0;
            else if (tval == '0 && periodic)
                tval <= init_val;
            else if (tval != '1)
                tval <= tval - 1'b1;     // one-shot parks at all ones
        end
    end

endmodule

`default_nettype wire

//--- hdl/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // privileged operation handed over by the pipeline
    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_CSRRD   = 3'd1,
        OP_CSRWR   = 3'd2,
        OP_CSRXCHG = 3'd3,
        OP_ERTN    = 3'd4,
        OP_EXCP    = 3'd5,
        OP_INT     = 3'd6   // only made by the issue stage
    } csr_op_t;

    typedef logic [13:0] csr_num_t;

    typedef logic [5:0] ecode_t;

endpackage

`default_nettype wire

//--- hdl/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

`define XLEN        32
`define HWI_N       8
`define TIMER_N     32
`define LIE_TI_BIT  11

// csr numbers
`define CSR_CRMD    14'h000
`define CSR_PRMD    14'h001
`define CSR_ECFG    14'h004
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_EENTRY  14'h00c
`define CSR_SAVE0   14'h030
`define CSR_SAVE1   14'h031
`define CSR_SAVE2   14'h032
`define CSR_SAVE3   14'h033
`define CSR_TID     14'h040
`define CSR_TCFG    14'h041
`define CSR_TVAL    14'h042
`define CSR_TICLR   14'h044

`define ECODE_INT   6'h00
`define CRMD_RESET  32'h0000_0008  // da set, plv 0, ie 0

`endif
